// File: stream_scaler.f
hw/stream_scaler_pkg.sv
hw/pipeline_core.sv
hw/pipeline.sv
hw/scale_unit.sv
hw/scaler_ctrl.sv
hw/stream_scaler.sv
sim/stream_scaler_sva.sv
sim/stream_scaler_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the stream_scaler testbench with Verilator and run it.
# The run passes only if the simulation output holds the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module stream_scaler_tb \
  -f stream_scaler.f \
  -o stream_scaler_sim &&
./obj_dir/stream_scaler_sim | tee /dev/stderr | grep -x "all tests passed" > /dev/null &&
echo "run_sim: PASS" ||
{ echo "run_sim: FAIL"; exit 1; }

// File: sim/stream_scaler_tb.sv
/*
  Testbench for the stream scaler
  - Clock, reset and LFSR driven stimulus
  - APB read and write tasks, register checks
  - Reference model queue fed by an input monitor, checked at the output
  - Six directed tests with one report line each
*/

`timescale 1ns/10ps

module stream_scaler_tb import stream_scaler_pkg::*; ();

  localparam int          WAIT_CYCLES  = 200;    // Handshake timeout
  localparam int          DRAIN_CYCLES = 4000;   // Output drain timeout
  localparam logic [31:0] SEED         = 32'h80df_7f5a;

  logic     clk       = 1'b0;
  logic     reset     = 1'b1;
  apb_req_t apb_req   = '0;
  apb_rsp_t apb_rsp;
  sample_t  in_data   = '0;
  logic     in_valid  = 1'b0;
  logic     in_ready;
  sample_t  out_data;
  logic     out_valid;
  logic     out_ready = 1'b1;

  logic [31:0] lfsr_q   = SEED;                  // Stimulus stream
  logic [31:0] rdy_lfsr = SEED;                  // Ready pattern with its own state
  logic        bp_en    = 1'b0;

  logic                     cur_bypass = 1'b0;   // Configuration as last written
  logic [GAIN_W-1:0]        cur_gain   = GAIN_RESET;
  logic signed [DATA_W-1:0] cur_offset = '0;

  scaled_t exp_q[$];
  int      errors       = 0;
  int      n_in         = 0;
  int      exp_clips    = 0;
  int      tests_run    = 0;
  int      tests_failed = 0;

  always #10 clk = ~clk;

  stream_scaler DUT (
    .clk_i       ( clk       ),
    .reset_i     ( reset     ),
    .apb_req_i   ( apb_req   ),
    .apb_rsp_o   ( apb_rsp   ),
    .in_data_i   ( in_data   ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .out_data_o  ( out_data  ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready )
  );

  bind stream_scaler stream_scaler_sva u_sva (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .apb_req_i   ( apb_req_i   ),
    .apb_rsp_o   ( apb_rsp_o   ),
    .in_data_i   ( in_data_i   ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .out_data_o  ( out_data_o  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i )
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Integer floor division by 256 followed by offset and saturation
  function automatic scaled_t expected_out(input logic signed [DATA_W-1:0] s);
    longint  p;
    longint  q;
    longint  r;
    scaled_t e;
    e.clipped = 1'b0;
    e.data    = s;
    if (cur_bypass) return e;
    p = longint'(s) * longint'(cur_gain);
    q = p / 256;
    if (p < 0 && (p % 256) != 0) q = q - 1;
    r = q + longint'(cur_offset);
    if (r > 32767) begin
      e.data    = 16'h7fff;
      e.clipped = 1'b1;
    end else if (r < -32768) begin
      e.data    = 16'h8000;
      e.clipped = 1'b1;
    end else begin
      e.data = r[DATA_W-1:0];
    end
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("tests run %0d, with errors %0d, error count %0d",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic abort_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    errors++;
    finish_run();
  endtask

  task automatic end_test(input string name, input int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - err_mark);
    end
  endtask

  task automatic wait_pready();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!apb_rsp.pready && cnt < WAIT_CYCLES) begin
      @(negedge clk);
      cnt++;
    end
    if (!apb_rsp.pready) abort_timeout("pready");
  endtask

  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data,
                           output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    wait_pready();
    err = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
    if (!err) begin
      case (addr)
        ADDR_CTRL:   cur_bypass = data[1];
        ADDR_GAIN:   cur_gain   = data[GAIN_W-1:0];
        ADDR_OFFSET: cur_offset = data[DATA_W-1:0];
        default: ;
      endcase
    end
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    wait_pready();
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_value("pslverr", err, 0);
  endtask

  task automatic check_reg(input logic [APB_ADDR_W-1:0] addr, input string name,
                           input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_read(addr, rd, err);
    check_value("pslverr", err, 0);
    check_value(name, rd, exp);
  endtask

  task automatic wait_in_ready();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!in_ready && cnt < WAIT_CYCLES) begin
      @(negedge clk);
      cnt++;
    end
    if (!in_ready) abort_timeout("in_ready_o");
  endtask

  // Returns once the sample is seen accepted; the transfer is on the next edge
  task automatic send_sample(input logic [DATA_W-1:0] value);
    @(posedge clk);
    in_valid     <= 1'b1;
    in_data.data <= value;
    wait_in_ready();
  endtask

  task automatic send_random(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = rand_bits(DATA_W);
      send_sample(r[DATA_W-1:0]);
    end
  endtask

  task automatic idle_input();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < DRAIN_CYCLES) begin
      @(negedge clk);
      cnt++;
    end
    if (exp_q.size() != 0) abort_timeout("the output stream to drain");
  endtask

  // Random output ready while back-pressure is on
  always @(posedge clk) begin
    if (bp_en) begin
      rdy_lfsr = lfsr_step(rdy_lfsr);
      out_ready <= rdy_lfsr[0];
    end else begin
      out_ready <= 1'b1;
    end
  end

  // Transfers are seen mid-cycle and happen on the following rising edge
  always @(negedge clk) begin : monitor
    scaled_t exp_item;
    if (!reset && in_valid && in_ready) begin
      exp_q.push_back(expected_out(in_data.data));
      n_in++;
    end
    if (!reset && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("output transfer at %0t with no sample outstanding", $time);
        errors++;
      end else begin
        exp_item = exp_q.pop_front();
        check_value("out_data_o", out_data.data, exp_item.data);
        if (exp_item.clipped) exp_clips++;
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] rd;
    logic        err;
    int          mark;
    int          accepted;
    int          clips_before;

    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // Reset values and a full input pipe while disabled
    mark = errors;
    check_reg(ADDR_CTRL, "CTRL", 32'h0);
    check_reg(ADDR_GAIN, "GAIN", 32'(GAIN_RESET));
    check_reg(ADDR_OFFSET, "OFFSET", 32'h0);
    check_reg(ADDR_OUT_COUNT, "OUT_COUNT", 32'h0);
    check_reg(ADDR_CLIP_COUNT, "CLIP_COUNT", 32'h0);
    accepted = 0;
    r = rand_bits(DATA_W);
    @(posedge clk);
    in_valid     <= 1'b1;
    in_data.data <= r[DATA_W-1:0];
    for (int i = 0; i < 4 * IN_STAGES; i++) begin
      @(negedge clk);
      check_value("out_valid_o", out_valid, 0);
      if (!in_ready) break;
      accepted++;
      r = rand_bits(DATA_W);
      @(posedge clk);
      in_data.data <= r[DATA_W-1:0];
    end
    check_value("in_ready_o", in_ready, 0);
    assert (accepted <= 2 * IN_STAGES) else begin
      $display("input took %0d samples while the scaler was disabled", accepted);
      errors++;
    end
    fork
      write_reg(ADDR_CTRL, 32'h1);
      begin
        wait_in_ready();
        idle_input();
      end
    join
    wait_drain();
    end_test("reset state", mark);

    mark = errors;
    write_reg(ADDR_GAIN, rand_bits(10));
    write_reg(ADDR_OFFSET, rand_bits(DATA_W));
    send_random(200);
    idle_input();
    wait_drain();
    end_test("scaling", mark);

    // Large gain pushes most results past both limits
    mark = errors;
    write_reg(ADDR_GAIN, 32'h7f00);
    write_reg(ADDR_OFFSET, 32'h1000);
    for (int i = 0; i < 40; i++) begin
      r = (i == 0) ? 32'h4000 : (i == 1) ? 32'hc000 : rand_bits(DATA_W);
      send_sample(r[DATA_W-1:0]);
    end
    idle_input();
    wait_drain();
    check_reg(ADDR_CLIP_COUNT, "CLIP_COUNT", exp_clips);
    end_test("saturation", mark);

    mark = errors;
    clips_before = exp_clips;
    write_reg(ADDR_CTRL, 32'h3);
    send_random(32);
    idle_input();
    wait_drain();
    check_reg(ADDR_CLIP_COUNT, "CLIP_COUNT", clips_before);
    end_test("bypass", mark);

    mark = errors;
    write_reg(ADDR_CTRL, 32'h1);
    write_reg(ADDR_GAIN, rand_bits(9));
    write_reg(ADDR_OFFSET, rand_bits(8));
    @(negedge clk);
    bp_en = 1'b1;
    send_random(200);
    idle_input();
    wait_drain();
    @(negedge clk);
    bp_en = 1'b0;
    check_reg(ADDR_OUT_COUNT, "OUT_COUNT", n_in);
    end_test("back-pressure", mark);

    mark = errors;
    apb_read(8'h14, rd, err);
    check_value("pslverr", err, 1);
    apb_write(ADDR_OUT_COUNT, 32'h55, err);
    check_value("pslverr", err, 1);
    check_reg(ADDR_CTRL, "CTRL", 32'h1);
    check_reg(ADDR_OUT_COUNT, "OUT_COUNT", n_in);
    end_test("APB errors", mark);

    finish_run();
  end

endmodule

// File: sim/stream_scaler_sva.sv
/*
  Bound assertions for the stream scaler
  - Output valid cleared by reset
  - Hold rules for the output and input streams under back-pressure
  - APB pready and pslverr response rules
*/

`timescale 1ns/10ps

module stream_scaler_sva import stream_scaler_pkg::*; (
  input logic     clk_i,
  input logic     reset_i,
  input apb_req_t apb_req_i,
  input apb_rsp_t apb_rsp_o,
  input sample_t  in_data_i,
  input logic     in_valid_i,
  input logic     in_ready_o,
  input sample_t  out_data_o,
  input logic     out_valid_o,
  input logic     out_ready_i
);

  logic access;
  logic mapped;
  logic cnt_write;

  assign access    = apb_req_i.psel & apb_req_i.penable;  // APB access phase
  assign mapped    = apb_req_i.paddr inside {ADDR_CTRL, ADDR_GAIN, ADDR_OFFSET,
                                             ADDR_OUT_COUNT, ADDR_CLIP_COUNT};
  assign cnt_write = apb_req_i.pwrite & ((apb_req_i.paddr == ADDR_OUT_COUNT) ||
                                         (apb_req_i.paddr == ADDR_CLIP_COUNT));

  a_out_valid_reset: assert property (@(posedge clk_i) reset_i |=> !out_valid_o)
    else $error("out_valid_o high in the cycle after reset");

  // A stalled output item stays put until it is taken
  a_out_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else $error("output stream changed while stalled");

  a_in_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i))
    else $error("input stimulus changed while stalled");

  a_slverr: assert property (@(posedge clk_i) disable iff (reset_i)
    apb_rsp_o.pslverr == (access && (!mapped || cnt_write)))
    else $error("pslverr does not match the access");

  a_pready: assert property (@(posedge clk_i) disable iff (reset_i)
    access |-> apb_rsp_o.pready)
    else $error("pready low in an access phase");

endmodule

// File: hw/stream_scaler.sv
/*
  Stream scaler top level
  - Input elastic pipeline, scale unit, output elastic pipeline
  - APB control block with configuration and counters
*/

`timescale 1ns/10ps

module stream_scaler import stream_scaler_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,

  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,

  input  sample_t  in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,

  output sample_t  out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  scaler_cfg_t cfg;
  sample_t     mid_data;
  logic        mid_valid;
  logic        mid_ready;
  scaled_t     scl_data;
  logic        scl_valid;
  logic        scl_ready;
  scaled_t     out_scaled;
  logic        out_fire;

  pipeline #(
    .WIDTH      ($bits(sample_t)),
    .NUM_STAGES (IN_STAGES)
  ) u_in_pipe (
    .clk_i   ( clk_i      ),
    .reset_i ( reset_i    ),
    .data_i  ( in_data_i  ),
    .valid_i ( in_valid_i ),
    .ready_o ( in_ready_o ),
    .data_o  ( mid_data   ),
    .valid_o ( mid_valid  ),
    .ready_i ( mid_ready  )
  );

  scale_unit u_scale (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .cfg_i       ( cfg       ),
    .in_data_i   ( mid_data  ),
    .in_valid_i  ( mid_valid ),
    .in_ready_o  ( mid_ready ),
    .out_data_o  ( scl_data  ),
    .out_valid_o ( scl_valid ),
    .out_ready_i ( scl_ready )
  );

  pipeline #(
    .WIDTH      ($bits(scaled_t)),
    .NUM_STAGES (OUT_STAGES)
  ) u_out_pipe (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .data_i  ( scl_data    ),
    .valid_i ( scl_valid   ),
    .ready_o ( scl_ready   ),
    .data_o  ( out_scaled  ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i )
  );

  assign out_data_o.data = out_scaled.data;
  assign out_fire        = out_valid_o & out_ready_i;  // Counted output transfer

  scaler_ctrl u_ctrl (
    .clk_i         ( clk_i              ),
    .reset_i       ( reset_i            ),
    .apb_req_i     ( apb_req_i          ),
    .apb_rsp_o     ( apb_rsp_o          ),
    .cfg_o         ( cfg                ),
    .out_fire_i    ( out_fire           ),
    .out_clipped_i ( out_scaled.clipped )
  );

endmodule

// File: hw/scaler_ctrl.sv
/*
  APB configuration and status registers
  - CTRL, GAIN and OFFSET configuration registers
  - OUT_COUNT and CLIP_COUNT read-only counters
  - Zero wait states, pslverr on unmapped or read-only access
*/

`timescale 1ns/10ps

module scaler_ctrl import stream_scaler_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,

  input  apb_req_t    apb_req_i,
  output apb_rsp_t    apb_rsp_o,

  output scaler_cfg_t cfg_o,

  input  logic        out_fire_i,
  input  logic        out_clipped_i
);

  scaler_cfg_t           cfg_q;
  logic [APB_DATA_W-1:0] out_count_q;
  logic [APB_DATA_W-1:0] clip_count_q;
  logic [APB_DATA_W-1:0] rdata;
  logic                  access;
  logic                  addr_hit;
  logic                  cnt_addr;
  logic                  err;
  logic                  wr_en;

  assign access = apb_req_i.psel & apb_req_i.penable;  // No wait states

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (apb_req_i.paddr)
      ADDR_CTRL:       rdata = {{(APB_DATA_W-2){1'b0}}, cfg_q.bypass, cfg_q.enable};
      ADDR_GAIN:       rdata = {{(APB_DATA_W-GAIN_W){1'b0}}, cfg_q.gain};
      ADDR_OFFSET:     rdata = {{(APB_DATA_W-DATA_W){cfg_q.offset[DATA_W-1]}}, cfg_q.offset};
      ADDR_OUT_COUNT:  rdata = out_count_q;
      ADDR_CLIP_COUNT: rdata = clip_count_q;
      default:         addr_hit = 1'b0;
    endcase
  end

  assign cnt_addr = (apb_req_i.paddr == ADDR_OUT_COUNT) ||
                    (apb_req_i.paddr == ADDR_CLIP_COUNT);
  assign err      = access & (~addr_hit | (apb_req_i.pwrite & cnt_addr));
  assign wr_en    = access & apb_req_i.pwrite & ~err;

  // Configuration registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q.enable <= 1'b0;
      cfg_q.bypass <= 1'b0;
      cfg_q.gain   <= GAIN_RESET;
      cfg_q.offset <= '0;
    end else if (wr_en) begin
      case (apb_req_i.paddr)
        ADDR_CTRL: begin
          cfg_q.enable <= apb_req_i.pwdata[0];
          cfg_q.bypass <= apb_req_i.pwdata[1];
        end
        ADDR_GAIN:   cfg_q.gain   <= apb_req_i.pwdata[GAIN_W-1:0];
        ADDR_OFFSET: cfg_q.offset <= apb_req_i.pwdata[DATA_W-1:0];
        default: ;
      endcase
    end
  end

  // Output transfer counters, cleared only by reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_count_q  <= '0;
      clip_count_q <= '0;
    end else if (out_fire_i) begin
      out_count_q <= out_count_q + 1'b1;
      if (out_clipped_i) begin
        clip_count_q <= clip_count_q + 1'b1;
      end
    end
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = err;

  assign cfg_o = cfg_q;

endmodule

// File: hw/scale_unit.sv
/*
  Gain, offset and saturation stage
  - Signed sample times unsigned Q8.8 gain, floor shift, signed offset
  - Saturation to the signed sample range with a clip flag
  - Bypass path and enable gating of the input handshake
  - Result registered through one elastic stage
*/

`timescale 1ns/10ps

module scale_unit import stream_scaler_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,

  input  scaler_cfg_t cfg_i,

  input  sample_t     in_data_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,

  output scaled_t     out_data_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  logic signed [PROD_W-1:0] product;
  logic signed [PROD_W-1:0] shifted;
  logic signed [SUM_W-1:0]  sum;
  logic                     sat_hi;
  logic                     sat_lo;
  scaled_t                  result;
  logic                     core_ready;

  assign product = $signed(in_data_i.data) * $signed({1'b0, cfg_i.gain});
  assign shifted = product >>> GAIN_FRAC;        // Arithmetic shift rounds toward -inf
  assign sum     = shifted + $signed(cfg_i.offset);

  // Out of range when the bits above the sample sign differ from the top bit
  assign sat_hi = ~sum[SUM_W-1] & (|sum[SUM_W-2:DATA_W-1]);
  assign sat_lo =  sum[SUM_W-1] & ~(&sum[SUM_W-2:DATA_W-1]);

  always_comb begin
    result.clipped = 1'b0;
    if (cfg_i.bypass) begin
      result.data = in_data_i.data;
    end else if (sat_hi) begin
      result.data    = {1'b0, {(DATA_W-1){1'b1}}};  // +32767
      result.clipped = 1'b1;
    end else if (sat_lo) begin
      result.data    = {1'b1, {(DATA_W-1){1'b0}}};  // -32768
      result.clipped = 1'b1;
    end else begin
      result.data = sum[DATA_W-1:0];
    end
  end

  pipeline_core #(
    .WIDTH ($bits(scaled_t))
  ) u_core (
    .clk_i   ( clk_i                   ),
    .reset_i ( reset_i                 ),
    .data_i  ( result                  ),
    .valid_i ( in_valid_i & cfg_i.enable ),
    .ready_o ( core_ready              ),
    .data_o  ( out_data_o              ),
    .valid_o ( out_valid_o             ),
    .ready_i ( out_ready_i             )
  );

  assign in_ready_o = core_ready & cfg_i.enable;  // Samples wait upstream while disabled

endmodule

// File: hw/pipeline.sv
/*
  Chain of elastic register stages
  - NUM_STAGES = 0 gives a plain pass-through
  - NUM_STAGES = 1 gives a single stage
  - Otherwise first, middle and last stages linked through arrays
*/

`timescale 1ns/10ps

module pipeline #(
  parameter int WIDTH      = 16,
  parameter int NUM_STAGES = 1
) (
  input  logic             clk_i,
  input  logic             reset_i,

  input  logic [WIDTH-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,

  output logic [WIDTH-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i
);

  generate
    if (NUM_STAGES == 0) begin : g_bypass
      assign data_o  = data_i;
      assign valid_o = valid_i;
      assign ready_o = ready_i;
    end else if (NUM_STAGES == 1) begin : g_single
      pipeline_core #(
        .WIDTH (WIDTH)
      ) u_pipeline_core (
        .clk_i   ( clk_i   ),
        .reset_i ( reset_i ),
        .data_i  ( data_i  ),
        .valid_i ( valid_i ),
        .ready_o ( ready_o ),
        .data_o  ( data_o  ),
        .valid_o ( valid_o ),
        .ready_i ( ready_i )
      );
    end else begin : g_chain
      logic [WIDTH-1:0] data_s  [NUM_STAGES-1];  // Links between stages
      logic             valid_s [NUM_STAGES-1];
      logic             ready_s [NUM_STAGES-1];

      pipeline_core #(
        .WIDTH (WIDTH)
      ) u_pipeline_core_first (
        .clk_i   ( clk_i      ),
        .reset_i ( reset_i    ),
        .data_i  ( data_i     ),
        .valid_i ( valid_i    ),
        .ready_o ( ready_o    ),
        .data_o  ( data_s[0]  ),
        .valid_o ( valid_s[0] ),
        .ready_i ( ready_s[0] )
      );

      for (genvar i = 0; i < NUM_STAGES - 2; i++) begin : g_middle
        pipeline_core #(
          .WIDTH (WIDTH)
        ) u_pipeline_core_middle (
          .clk_i   ( clk_i        ),
          .reset_i ( reset_i      ),
          .data_i  ( data_s[i]    ),
          .valid_i ( valid_s[i]   ),
          .ready_o ( ready_s[i]   ),
          .data_o  ( data_s[i+1]  ),
          .valid_o ( valid_s[i+1] ),
          .ready_i ( ready_s[i+1] )
        );
      end

      pipeline_core #(
        .WIDTH (WIDTH)
      ) u_pipeline_core_last (
        .clk_i   ( clk_i                 ),
        .reset_i ( reset_i               ),
        .data_i  ( data_s[NUM_STAGES-2]  ),
        .valid_i ( valid_s[NUM_STAGES-2] ),
        .ready_o ( ready_s[NUM_STAGES-2] ),
        .data_o  ( data_o                ),
        .valid_o ( valid_o               ),
        .ready_i ( ready_i               )
      );
    end
  endgenerate

endmodule

// File: hw/pipeline_core.sv
/*
  Single elastic register stage for a valid/ready stream
  - Main register drives the output side
  - Skid register catches the item arriving during a stall
  - ready_o comes straight from the skid valid flop
*/

`timescale 1ns/10ps

module pipeline_core #(
  parameter int WIDTH = 16
) (
  input  logic             clk_i,
  input  logic             reset_i,

  input  logic [WIDTH-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,

  output logic [WIDTH-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i
);

  logic [WIDTH-1:0] data_q;
  logic             valid_q;
  logic [WIDTH-1:0] skid_data_q;
  logic             skid_valid_q;
  logic             load_main;

  assign load_main = ~valid_q | ready_i;         // Main register is free this cycle

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q      <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (load_main) begin
      valid_q      <= skid_valid_q | valid_i;   // Skid entry drains first
      skid_valid_q <= 1'b0;
    end else if (valid_i && !skid_valid_q) begin
      skid_valid_q <= 1'b1;                     // Downstream stalled, park input
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main) begin
      data_q <= skid_valid_q ? skid_data_q : data_i;
    end
    if (!skid_valid_q) begin
      skid_data_q <= data_i;                    // Only kept when skid valid rises
    end
  end

  assign ready_o = ~skid_valid_q;
  assign data_o  = data_q;
  assign valid_o = valid_q;

endmodule

// File: hw/stream_scaler_pkg.sv
/*
  Shared definitions for the stream scaler
  - Sample, gain and arithmetic widths
  - Elastic stage counts before and after the scale unit
  - APB register addresses and reset values
  - Stream and APB struct types
*/

package stream_scaler_pkg;

  localparam int DATA_W     = 16;                 // Sample width
  localparam int GAIN_W     = 16;                 // Unsigned Q8.8 gain
  localparam int GAIN_FRAC  = 8;                  // Fractional gain bits
  localparam int PROD_W     = DATA_W + GAIN_W + 1; // Signed sample x unsigned gain
  localparam int SUM_W      = PROD_W + 1;         // Room for the offset carry

  localparam int IN_STAGES  = 2;                  // Elastic stages before scaling
  localparam int OUT_STAGES = 1;                  // Elastic stages after scaling

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL       = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_GAIN       = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_OFFSET     = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_OUT_COUNT  = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] ADDR_CLIP_COUNT = 8'h10;

  localparam logic [GAIN_W-1:0] GAIN_RESET = 16'h0100; // Unity gain

  typedef struct packed {
    logic signed [DATA_W-1:0] data;
  } sample_t;

  typedef struct packed {
    logic signed [DATA_W-1:0] data;
    logic                     clipped;            // Result was saturated
  } scaled_t;

  typedef struct packed {
    logic                     enable;
    logic                     bypass;
    logic        [GAIN_W-1:0] gain;
    logic signed [DATA_W-1:0] offset;
  } scaler_cfg_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage
